//--- src/l1Pkg.sv
`default_nettype none

package l1Pkg;

    //////////////////////////////
    // detector format constants
    //////////////////////////////

    // circular buffer, one entry per bunch crossing
    localparam int bufferDepth = 512;
    // clocks between hit write and the L1A that fetches it
    localparam int l1Latency = 128;
    // no L1A before the buffer has been filled once
    localparam int startupCycles = 512;
    // periodic mode wraps here, one L1A every 41 clocks
    localparam int periodicCount = 40;

    // prbs word taken from the 31-bit register
    localparam int prbsWidth = 15;
    // alternating pattern, top bit clear
    localparam logic [30:0] prbsSeed = 31'h2AAAAAAA;
    // about 1/40 of the 15-bit range
    localparam int l1aThreshold = 819;

    // readout side
    localparam int queueDepth = 16;
    localparam int creditMax = 4;

    //////////////////////////////
    // vector types
    //////////////////////////////

    // bunch counter, also the buffer address
    typedef logic [8:0] bunchIdT;
    // opaque hit payload
    typedef logic [13:0] hitWordT;
    typedef logic [prbsWidth-1:0] prbsWordT;
    // header or data word on the output
    typedef logic [15:0] frameWordT;
    // accepted event count, wraps at 32
    typedef logic [4:0] eventNumT;

    // hand-over from buffer fetch to framer
    typedef struct packed {
        logic valid;
        bunchIdT bunchId;
        hitWordT hit;
    } l1EventT;

endpackage

`default_nettype wire

//--- src/prbs31.sv
`timescale 1ns/10ps
`default_nettype none

module prbs31 import l1Pkg::*;
(
    input  logic clkTMR,
    input  logic reset,
    input  logic pause,
    output prbsWordT prbsWord
);

    // fibonacci register, x^31 + x^28 + 1
    logic [30:0] state;
    logic [30:0] nextState;

    //////////////////////////////
    // 15 shift steps per clock
    //////////////////////////////

    always_comb
    begin
        nextState = state;
        // each step shifts left, feedback into bit 0
        for (int i = 0; i < prbsWidth; i++)
        begin
            nextState = {nextState[29:0], nextState[30] ^ nextState[27]};
        end
    end

    always_ff @(posedge clkTMR)
    begin
        if (reset)
        begin
            state <= prbsSeed;
        end
        else if (!pause)
        begin
            state <= nextState;
        end
    end

    // low bits form the random word
    assign prbsWord = state[prbsWidth-1:0];

endmodule

`default_nettype wire

//--- src/testL1Generator.sv
`timescale 1ns/10ps
`default_nettype none

module testL1Generator import l1Pkg::*;
(
    input  logic clkTMR,
    input  logic reset,
    input  logic triggerDisable,
    input  logic triggerMode,
    output logic l1a
);

    prbsWordT prbsWord;
    logic prbsPause;
    logic countPause;

    // prbs only runs in random mode
    assign prbsPause = triggerDisable | ~triggerMode;
    // periodic counter only runs in periodic mode
    assign countPause = triggerDisable | triggerMode;

    prbs31 prbs31_i
    (
        .clkTMR(clkTMR),
        .reset(reset),
        .pause(prbsPause),
        .prbsWord(prbsWord)
    );

    //////////////////////////////
    // startup holdoff
    //////////////////////////////

    logic [9:0] startCount;
    logic started;

    // counter stops once started is set
    always_ff @(posedge clkTMR)
    begin
        if (reset)
        begin
            startCount <= '0;
            started <= 1'b0;
        end
        else if (!started)
        begin
            startCount <= startCount + 10'd1;
            if (startCount == 10'(startupCycles))
            begin
                started <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // periodic source
    //////////////////////////////

    logic [5:0] trigCount;

    always_ff @(posedge clkTMR)
    begin
        if (reset)
        begin
            trigCount <= '0;
        end
        else if (!countPause)
        begin
            // wrap at terminal value
            if (trigCount == 6'(periodicCount))
            begin
                trigCount <= '0;
            end
            else
            begin
                trigCount <= trigCount + 6'd1;
            end
        end
    end

    // disable only freezes the sources, the compare still stands
    assign l1a = started &
        (triggerMode ? (prbsWord < prbsWordT'(l1aThreshold))
                     : (trigCount == 6'(periodicCount)));

endmodule

`default_nettype wire

//--- src/hitBuffer.sv
`timescale 1ns/10ps
`default_nettype none

module hitBuffer import l1Pkg::*;
(
    input  logic clkTMR,
    input  logic reset,
    input  hitWordT hitIn,
    input  logic l1a,
    output l1EventT l1Event
);

    //////////////////////////////
    // bunch counter
    //////////////////////////////

    // doubles as write pointer, wraps at 512
    bunchIdT bunchCount;

    always_ff @(posedge clkTMR)
    begin
        if (reset)
        begin
            bunchCount <= '0;
        end
        else
        begin
            bunchCount <= bunchCount + bunchIdT'(1);
        end
    end

    //////////////////////////////
    // circular buffer
    //////////////////////////////

    hitWordT hitMem [bufferDepth];
    bunchIdT readAddr;

    // fixed latency behind the write pointer
    assign readAddr = bunchCount - bunchIdT'(l1Latency);

    // write every clock, read address never equals write address
    always_ff @(posedge clkTMR)
    begin
        hitMem[bunchCount] <= hitIn;
    end

    //////////////////////////////
    // event register
    //////////////////////////////

    logic eventValid;
    bunchIdT eventBunch;
    hitWordT eventHit;

    // one-clock valid pulse after the L1A edge
    always_ff @(posedge clkTMR)
    begin
        if (reset)
        begin
            eventValid <= 1'b0;
        end
        else
        begin
            eventValid <= l1a;
        end
    end

    // payload held until the next L1A
    always_ff @(posedge clkTMR)
    begin
        if (l1a)
        begin
            eventBunch <= readAddr;
            eventHit <= hitMem[readAddr];
        end
    end

    assign l1Event = '{valid: eventValid, bunchId: eventBunch, hit: eventHit};

endmodule

`default_nettype wire

//--- src/eventFramer.sv
`timescale 1ns/10ps
`default_nettype none

module eventFramer import l1Pkg::*;
(
    input  logic clkTMR,
    input  logic reset,
    input  l1EventT l1Event,
    input  logic creditReturn,
    output frameWordT frameOut,
    output logic frameValid,
    output logic overflow
);

    //////////////////////////////
    // event queue
    //////////////////////////////

    // header and data words built at push time
    frameWordT headerMem [queueDepth];
    frameWordT dataMem [queueDepth];
    logic [$clog2(queueDepth)-1:0] wrPtr;
    logic [$clog2(queueDepth)-1:0] rdPtr;
    logic [$clog2(queueDepth):0] fill;
    eventNumT eventNum;
    logic queueFull;
    logic push;
    logic pop;

    // top bit of fill only set at exactly queueDepth entries
    assign queueFull = fill[$clog2(queueDepth)];
    assign push = l1Event.valid & ~queueFull;

    always_ff @(posedge clkTMR)
    begin
        if (push)
        begin
            // marker 10, event number, bunch id
            headerMem[wrPtr] <= {2'b10, eventNum, l1Event.bunchId};
            // marker 01, hit payload
            dataMem[wrPtr] <= {2'b01, l1Event.hit};
        end
    end

    always_ff @(posedge clkTMR)
    begin
        if (reset)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill <= '0;
            eventNum <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (push)
            begin
                wrPtr <= wrPtr + 1'b1;
                eventNum <= eventNum + eventNumT'(1);
            end
            if (pop)
            begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10: fill <= fill + 1'b1;
                2'b01: fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // sticky, lost event
            if (l1Event.valid && queueFull)
            begin
                overflow <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // serializer and credits
    //////////////////////////////

    // 0 header phase, 1 data phase
    logic dataPhase;
    logic [2:0] credit;

    // one word per clock while queue holds an event and credit remains
    assign frameValid = (fill != '0) && (credit != '0);
    assign frameOut = dataPhase ? dataMem[rdPtr] : headerMem[rdPtr];
    // event leaves after its data word
    assign pop = frameValid & dataPhase;

    always_ff @(posedge clkTMR)
    begin
        if (reset)
        begin
            dataPhase <= 1'b0;
            credit <= 3'(creditMax);
        end
        else
        begin
            if (frameValid)
            begin
                dataPhase <= ~dataPhase;
            end
            // return and send may coincide
            case ({creditReturn, frameValid})
                2'b10: credit <= credit + 3'd1;
                2'b01: credit <= credit - 3'd1;
                default: credit <= credit;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/testReadoutTop.sv
`timescale 1ns/10ps
`default_nettype none

module testReadoutTop import l1Pkg::*;
(
    input  logic clkTMR,
    input  logic reset,
    input  logic triggerDisable,
    input  logic triggerMode,
    input  hitWordT hitIn,
    input  logic creditReturn,
    output logic l1a,
    output frameWordT frameOut,
    output logic frameValid,
    output logic overflow
);

    // fetched event into the framer
    l1EventT l1Event;

    //////////////////////////////
    // trigger, fetch, framing
    //////////////////////////////

    // stage 1, combinational trigger, also a top port
    testL1Generator testL1Generator_i
    (
        .clkTMR(clkTMR),
        .reset(reset),
        .triggerDisable(triggerDisable),
        .triggerMode(triggerMode),
        .l1a(l1a)
    );

    // stage 2, one clock from l1a to event
    hitBuffer hitBuffer_i
    (
        .clkTMR(clkTMR),
        .reset(reset),
        .hitIn(hitIn),
        .l1a(l1a),
        .l1Event(l1Event)
    );

    // stage 3, queued two-word frames under credits
    eventFramer eventFramer_i
    (
        .clkTMR(clkTMR),
        .reset(reset),
        .l1Event(l1Event),
        .creditReturn(creditReturn),
        .frameOut(frameOut),
        .frameValid(frameValid),
        .overflow(overflow)
    );

endmodule

`default_nettype wire

//--- verification/tbTestReadout.sv
`timescale 1ns/10ps
`default_nettype none

module tbTestReadout import l1Pkg::*; ();

    logic clkTMR;
    logic reset;
    logic triggerDisable;
    logic triggerMode;
    logic creditReturn;
    hitWordT hitIn;
    logic l1a;
    frameWordT frameOut;
    logic frameValid;
    logic overflow;

    // reference model stepped once per clock
    logic [30:0] prbsModel;
    int cycleNum;
    int trigModel;
    bunchIdT bunchModel;
    hitWordT hitHistory [bufferDepth];
    l1EventT expQueue [$];
    // clock at which each received word's credit may go back
    int creditDue [$];
    logic starve;
    logic strictOrder;
    logic expectHeader;
    hitWordT pendingHit;
    int expEventNum;
    int wordsSent;
    int creditsReturned;
    int missingEvents;
    logic overflowSeen;

    testReadoutTop testReadoutTop_i (.*);

    initial
    begin
        clkTMR = 1'b0;
        forever #5 clkTMR = ~clkTMR;
    end

    //////////////////////////////
    // reporting
    //////////////////////////////

    task automatic stopOnError(string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic checkValue(string testName, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
        begin
            stopOnError($sformatf("[FAIL] %s expected %0d actual %0d",
                testName, expected, actual));
        end
    endtask

    // x^31 + x^28 + 1 with 15 shifts per clock
    function automatic logic [30:0] prbsAdvance(logic [30:0] s);
        logic [30:0] r;
        r = s;
        for (int i = 0; i < prbsWidth; i++)
        begin
            r = {r[29:0], r[30] ^ r[27]};
        end
        return r;
    endfunction

    //////////////////////////////
    // stimulus and consumer
    //////////////////////////////

    task automatic driveInputs();
        hitIn = hitWordT'($urandom);
        creditReturn = 1'b0;
        // at most one credit back per clock
        for (int i = 0; i < creditDue.size(); i++)
        begin
            if (!starve && creditDue[i] <= cycleNum)
            begin
                creditDue.delete(i);
                creditReturn = 1'b1;
                creditsReturned++;
                break;
            end
        end
    endtask

    task automatic receiveWord();
        l1EventT ev;
        int skipped;
        wordsSent++;
        creditDue.push_back(cycleNum + 1 + int'($urandom % 7));
        if (expectHeader)
        begin
            skipped = 0;
            checkValue("header marker", 2, frameOut[15:14]);
            checkValue("event number", expEventNum % 32, frameOut[13:9]);
            if (strictOrder && expQueue.size() > 0)
                checkValue("bunch id", expQueue[0].bunchId, frameOut[8:0]);
            // dropped events are passed over
            while (expQueue.size() > 0 && expQueue[0].bunchId != frameOut[8:0])
            begin
                void'(expQueue.pop_front());
                skipped++;
            end
            if (expQueue.size() == 0)
                stopOnError("a header arrived whose bunch id matches no expected event");
            missingEvents += skipped;
            ev = expQueue.pop_front();
            pendingHit = ev.hit;
            expEventNum++;
            expectHeader = 1'b0;
        end
        else
        begin
            // data must follow its own header
            checkValue("data marker", 1, frameOut[15:14]);
            checkValue("hit word", pendingHit, frameOut[13:0]);
            expectHeader = 1'b1;
        end
    endtask

    // outputs sampled mid-cycle before the model moves across the edge
    task automatic sampleCycle();
        logic expL1a;
        bunchIdT srcBunch;
        l1EventT ev;
        expL1a = (cycleNum > startupCycles) && (triggerMode ?
            (prbsModel[14:0] < 15'(l1aThreshold)) : (trigModel == periodicCount));
        if (cycleNum <= startupCycles)
            checkValue("holdoff l1a", 0, l1a);
        checkValue("l1a", expL1a, l1a);
        if (expL1a)
        begin
            srcBunch = bunchModel - bunchIdT'(l1Latency);
            ev.valid = 1'b1;
            ev.bunchId = srcBunch;
            ev.hit = hitHistory[srcBunch];
            expQueue.push_back(ev);
        end
        if (strictOrder)
            checkValue("no overflow", 0, overflow);
        if (overflowSeen)
            checkValue("overflow sticky", 1, overflow);
        overflowSeen = overflowSeen | overflow;
        if (frameValid)
            receiveWord();
        // a credit given back this clock is only spendable from the next one
        checkValue("credit bound", 1,
            wordsSent <= creditsReturned - int'(creditReturn) + creditMax);
        hitHistory[bunchModel] = hitIn;
        bunchModel++;
        // disable freezes whichever source is active
        if (!triggerDisable && triggerMode)
            prbsModel = prbsAdvance(prbsModel);
        if (!triggerDisable && !triggerMode)
            trigModel = (trigModel == periodicCount) ? 0 : trigModel + 1;
        cycleNum++;
    endtask

    task automatic stepCycle();
        driveInputs();
        @(negedge clkTMR);
        sampleCycle();
        @(posedge clkTMR);
        #1;
    endtask

    task automatic runCycles(int n);
        for (int i = 0; i < n; i++)
            stepCycle();
    endtask

    task automatic applyReset(logic mode);
        reset = 1'b1;
        triggerMode = mode;
        triggerDisable = 1'b0;
        creditReturn = 1'b0;
        repeat (8)
        begin
            @(posedge clkTMR);
            #1;
        end
        reset = 1'b0;
        prbsModel = 31'h2AAAAAAA;
        cycleNum = 0;
        trigModel = 0;
        bunchModel = '0;
        expQueue.delete();
        creditDue.delete();
        starve = 1'b0;
        strictOrder = 1'b1;
        expectHeader = 1'b1;
        expEventNum = 0;
        wordsSent = 0;
        creditsReturned = 0;
        missingEvents = 0;
        overflowSeen = 1'b0;
        checkValue("reset l1a", 0, l1a);
        checkValue("reset frameValid", 0, frameValid);
        checkValue("reset overflow", 0, overflow);
    endtask

    // until every expected event has left as a full frame
    task automatic waitDrained(int limit);
        int waited;
        waited = 0;
        while (expQueue.size() > 0 || !expectHeader)
        begin
            stepCycle();
            waited++;
            if (waited > limit)
                stopOnError("timeout while waiting for the event queue to drain");
        end
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial
    begin
        int waited;
        void'($urandom(67));
        reset = 1'b1;
        triggerDisable = 1'b0;
        triggerMode = 1'b0;
        creditReturn = 1'b0;
        hitIn = '0;
        // periodic mode
        applyReset(1'b0);
        runCycles(1500);
        waitDrained(2000);
        checkValue("periodic frame count", 1, expEventNum >= 20);
        // random mode with a freeze on a word above threshold
        applyReset(1'b1);
        runCycles(1500);
        waited = 0;
        while (prbsModel[14:0] < 15'(l1aThreshold))
        begin
            stepCycle();
            waited++;
            if (waited > 500)
                stopOnError("timeout while waiting for a quiet PRBS word");
        end
        triggerDisable = 1'b1;
        runCycles(60);
        triggerDisable = 1'b0;
        runCycles(1500);
        waitDrained(2000);
        checkValue("random frame count", 1, expEventNum >= 20);
        // starve credits under periodic triggers
        applyReset(1'b0);
        runCycles(600);
        waitDrained(2000);
        strictOrder = 1'b0;
        starve = 1'b1;
        waited = 0;
        while (!overflow)
        begin
            stepCycle();
            waited++;
            if (waited > 2000)
                stopOnError("timeout while waiting for the overflow flag");
        end
        runCycles(100);
        starve = 1'b0;
        runCycles(1000);
        waitDrained(2000);
        checkValue("overflow at end", 1, overflow);
        checkValue("events dropped", 1, missingEvents > 0);
        // sticky overflow has to clear on reset
        applyReset(1'b0);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
src/l1Pkg.sv
src/prbs31.sv
src/testL1Generator.sv
src/hitBuffer.sv
src/eventFramer.sv
src/testReadoutTop.sv
verification/tbTestReadout.sv

//--- Makefile
TOP = tbTestReadout

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Regression failed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Regression passed" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
